//--- flist.f
+incdir+src
src/gw_pkg.sv
src/gw_mem_if.sv
src/gw_tag_client.sv
src/gw_mem_router.sv
src/gw_host_mmio.sv
src/gw_dram_model.sv
src/gw_mem_top.sv
testbench/tb_gw_mem.sv

//--- src/gw_consts.svh
`ifndef GW_CONSTS_SVH
`define GW_CONSTS_SVH

// Bus widths
`define GW_ADDR_W 16
`define GW_DATA_W 32

// Node coordinate carried in the tag payload
`define GW_CORD_W 7

// Address map, host MMIO sits below the DRAM base
`define GW_DRAM_BASE 16'h8000

// DRAM model geometry and timing
`define GW_DRAM_WORDS 64
`define GW_DRAM_LATENCY 4

// Host register offsets
`define GW_REG_FINISH 0
`define GW_REG_SCRATCH 1

`endif

//--- src/gw_dram_model.sv
`timescale 1ns/1ns

`include "gw_consts.svh"

module gw_dram_model
  import gw_pkg::*;
  (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     soft_reset_i,
  gw_mem_if.target bus
);

  localparam int idx_w_lp = $clog2(`GW_DRAM_WORDS);
  localparam int cnt_w_lp = $clog2(`GW_DRAM_LATENCY + 1);

  data_t                mem_r [`GW_DRAM_WORDS];
  data_t                resp_data_r;
  dram_state_t          state_r;
  logic [cnt_w_lp-1:0]  lat_cnt_r;
  logic [idx_w_lp-1:0]  idx;
  logic                 accept;

  assign idx    = bus.cmd_addr[idx_w_lp-1:0];
  assign accept = bus.cmd_v & (state_r == DRAM_IDLE);

  assign bus.cmd_yumi  = accept;
  assign bus.resp_v    = (state_r == DRAM_RESP);
  assign bus.resp_data = resp_data_r;

  ////////////////////////////////////////
  // Latency FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r   <= DRAM_IDLE;
      lat_cnt_r <= '0;
    end
    else if (soft_reset_i)
    begin
      state_r   <= DRAM_IDLE;
      lat_cnt_r <= '0;
    end
    else
    begin
      case (state_r)
        DRAM_IDLE:
        begin
          if (accept)
          begin
            state_r   <= DRAM_WAIT;
            lat_cnt_r <= cnt_w_lp'(`GW_DRAM_LATENCY - 1);
          end
        end
        DRAM_WAIT:
        begin
          // Last wait cycle, response shows next cycle
          if (lat_cnt_r == cnt_w_lp'(1))
            state_r <= DRAM_RESP;
          lat_cnt_r <= lat_cnt_r - 1'b1;
        end
        DRAM_RESP:
        begin
          if (bus.resp_ready)
            state_r <= DRAM_IDLE;
        end
        default: state_r <= DRAM_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (bus.cmd_write)
      begin
        mem_r[idx]  <= bus.cmd_data;
        resp_data_r <= '0;
      end
      else
      begin
        resp_data_r <= mem_r[idx];
      end
    end
  end

endmodule

//--- src/gw_host_mmio.sv
`timescale 1ns/1ns

`include "gw_consts.svh"

module gw_host_mmio
  import gw_pkg::*;
  (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     soft_reset_i,
  gw_mem_if.target bus,
  output logic     finish_o
);

  localparam int ofs_w_lp = 8;

  logic                pending_r;
  logic                finish_r;
  data_t               scratch_r;
  data_t               resp_data_r;
  data_t               rd_data;
  logic [ofs_w_lp-1:0] ofs;
  logic                accept;

  assign ofs    = bus.cmd_addr[ofs_w_lp-1:0];
  assign accept = bus.cmd_v & ~pending_r;

  assign bus.cmd_yumi  = accept;
  assign bus.resp_v    = pending_r;
  assign bus.resp_data = resp_data_r;
  assign finish_o      = finish_r;

  // Read mux, writes answer with zero
  always_comb
  begin
    rd_data = '0;
    if (!bus.cmd_write)
    begin
      if (ofs == ofs_w_lp'(`GW_REG_SCRATCH))
        rd_data = scratch_r;
      else if (ofs == ofs_w_lp'(`GW_REG_FINISH))
        rd_data = data_t'(finish_r);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pending_r <= 1'b0;
      finish_r  <= 1'b0;
      scratch_r <= '0;
    end
    else
    begin
      if (soft_reset_i)
        pending_r <= 1'b0;
      else if (accept)
        pending_r <= 1'b1;
      else if (bus.resp_ready)
        pending_r <= 1'b0;

      if (accept && bus.cmd_write && (ofs == ofs_w_lp'(`GW_REG_FINISH)))
        finish_r <= 1'b1;
      if (accept && bus.cmd_write && (ofs == ofs_w_lp'(`GW_REG_SCRATCH)))
        scratch_r <= bus.cmd_data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      resp_data_r <= rd_data;
  end

endmodule

//--- src/gw_mem_if.sv
`timescale 1ns/1ns

interface gw_mem_if
  import gw_pkg::*;
  ();

  // Command channel, valid/yumi
  logic  cmd_v;
  addr_t cmd_addr;
  logic  cmd_write;
  data_t cmd_data;
  logic  cmd_yumi;

  // Response channel, valid/ready
  logic  resp_v;
  data_t resp_data;
  logic  resp_ready;

  modport router (
    output cmd_v,
    output cmd_addr,
    output cmd_write,
    output cmd_data,
    input  cmd_yumi,
    input  resp_v,
    input  resp_data,
    output resp_ready
  );

  modport target (
    input  cmd_v,
    input  cmd_addr,
    input  cmd_write,
    input  cmd_data,
    output cmd_yumi,
    output resp_v,
    output resp_data,
    input  resp_ready
  );

endinterface

//--- src/gw_mem_router.sv
`timescale 1ns/1ns

`include "gw_consts.svh"

module gw_mem_router
  import gw_pkg::*;
  (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            soft_reset_i,

  // Incoming command
  input  logic            cmd_v_i,
  input  addr_t           cmd_addr_i,
  input  logic            cmd_write_i,
  input  data_t           cmd_data_i,
  output logic            cmd_yumi_o,

  // Merged response
  output logic            resp_v_o,
  output data_t           resp_data_o,
  input  logic            resp_ready_i,

  gw_mem_if.router        host_bus,
  gw_mem_if.router        dram_bus
);

  logic outstanding_r;
  logic host_sel;
  logic offer_ok;
  logic resp_done;

  ////////////////////////////////////////
  // Command steering
  ////////////////////////////////////////

  assign host_sel = (cmd_addr_i < `GW_DRAM_BASE);
  assign offer_ok = cmd_v_i & ~outstanding_r & ~soft_reset_i;

  assign host_bus.cmd_v     = offer_ok & host_sel;
  assign host_bus.cmd_addr  = cmd_addr_i;
  assign host_bus.cmd_write = cmd_write_i;
  assign host_bus.cmd_data  = cmd_data_i;

  assign dram_bus.cmd_v     = offer_ok & ~host_sel;
  assign dram_bus.cmd_addr  = cmd_addr_i;
  assign dram_bus.cmd_write = cmd_write_i;
  assign dram_bus.cmd_data  = cmd_data_i;

  // Targets only yumi while offered, so the selected one decides
  assign cmd_yumi_o = host_sel ? host_bus.cmd_yumi : dram_bus.cmd_yumi;

  ////////////////////////////////////////
  // Response merge
  ////////////////////////////////////////

  assign resp_v_o    = host_bus.resp_v | dram_bus.resp_v;
  assign resp_data_o = host_bus.resp_v ? host_bus.resp_data : dram_bus.resp_data;

  assign host_bus.resp_ready = resp_ready_i;
  assign dram_bus.resp_ready = resp_ready_i;

  assign resp_done = resp_v_o & resp_ready_i;

  // One request in flight at a time
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      outstanding_r <= 1'b0;
    end
    else if (soft_reset_i)
    begin
      outstanding_r <= 1'b0;
    end
    else if (cmd_yumi_o)
    begin
      outstanding_r <= 1'b1;
    end
    else if (resp_done)
    begin
      outstanding_r <= 1'b0;
    end
  end

endmodule

//--- src/gw_mem_top.sv
`timescale 1ns/1ns

module gw_mem_top
  import gw_pkg::*;
  (
  input  logic  clk_i,
  input  logic  rst_n_i,

  // Tag configuration
  input  logic  tag_en_i,
  input  logic  tag_data_i,

  // Command channel
  input  logic  cmd_v_i,
  input  addr_t cmd_addr_i,
  input  logic  cmd_write_i,
  input  data_t cmd_data_i,
  output logic  cmd_yumi_o,

  // Response channel
  output logic  resp_v_o,
  output data_t resp_data_o,
  output cord_t resp_cord_o,
  input  logic  resp_ready_i,

  output logic  finish_o
);

  logic  soft_reset;
  cord_t cord;

  gw_mem_if host_bus ();
  gw_mem_if dram_bus ();

  gw_tag_client tag_client_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .tag_en_i     (tag_en_i),
    .tag_data_i   (tag_data_i),
    .soft_reset_o (soft_reset),
    .cord_o       (cord)
  );

  gw_mem_router mem_router_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .soft_reset_i (soft_reset),
    .cmd_v_i      (cmd_v_i),
    .cmd_addr_i   (cmd_addr_i),
    .cmd_write_i  (cmd_write_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_yumi_o   (cmd_yumi_o),
    .resp_v_o     (resp_v_o),
    .resp_data_o  (resp_data_o),
    .resp_ready_i (resp_ready_i),
    .host_bus     (host_bus.router),
    .dram_bus     (dram_bus.router)
  );

  gw_host_mmio host_mmio_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .soft_reset_i (soft_reset),
    .bus          (host_bus.target),
    .finish_o     (finish_o)
  );

  gw_dram_model dram_model_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .soft_reset_i (soft_reset),
    .bus          (dram_bus.target)
  );

  // Node position stamped on every response
  assign resp_cord_o = cord;

endmodule

//--- src/gw_pkg.sv
`include "gw_consts.svh"

package gw_pkg;

  ////////////////////////////////////////
  // Bus types
  ////////////////////////////////////////

  typedef logic [`GW_ADDR_W-1:0] addr_t;
  typedef logic [`GW_DATA_W-1:0] data_t;

  ////////////////////////////////////////
  // Tag client types
  ////////////////////////////////////////

  typedef logic [`GW_CORD_W-1:0] cord_t;

  // Soft reset in the top bit, coordinate below
  typedef logic [`GW_CORD_W:0] tag_payload_t;

  typedef logic [$clog2(`GW_CORD_W+2)-1:0] tag_cnt_t;

  // DRAM model FSM
  typedef enum logic [1:0] {
    DRAM_IDLE,
    DRAM_WAIT,
    DRAM_RESP
  } dram_state_t;

endpackage

//--- src/gw_tag_client.sv
`timescale 1ns/1ns

`include "gw_consts.svh"

module gw_tag_client
  import gw_pkg::*;
  (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  tag_en_i,
  input  logic  tag_data_i,
  output logic  soft_reset_o,
  output cord_t cord_o
);

  // Last bit index of the payload
  localparam tag_cnt_t last_bit_lp = tag_cnt_t'(`GW_CORD_W);

  logic [`GW_CORD_W-1:0] shift_r;
  tag_cnt_t              cnt_r;
  tag_payload_t          payload_r;

  ////////////////////////////////////////
  // Serial shift in, MSB first
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (tag_en_i)
    begin
      shift_r <= {shift_r[`GW_CORD_W-2:0], tag_data_i};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_r <= '0;
    end
    else if (tag_en_i)
    begin
      if (cnt_r == last_bit_lp)
        cnt_r <= '0;
      else
        cnt_r <= cnt_r + 1'b1;
    end
  end

  // Payload takes effect once all bits are in
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      payload_r <= {1'b1, {`GW_CORD_W{1'b0}}};
    end
    else if (tag_en_i && (cnt_r == last_bit_lp))
    begin
      payload_r <= {shift_r, tag_data_i};
    end
  end

  assign soft_reset_o = payload_r[`GW_CORD_W];
  assign cord_o       = payload_r[`GW_CORD_W-1:0];

endmodule

//--- testbench/tb_gw_mem.sv
`timescale 1ns/1ns

module tb_gw_mem
  import gw_pkg::*;
  ();

  localparam int host_lat_lp = 1;
  localparam int dram_lat_lp = 4;
  localparam int max_wait_lp = 50;

  logic  clk_i = 1'b0;
  logic  rst_n_i;
  logic  tag_en_i;
  logic  tag_data_i;
  logic  cmd_v_i;
  addr_t cmd_addr_i;
  logic  cmd_write_i;
  data_t cmd_data_i;
  logic  cmd_yumi_o;
  logic  resp_v_o;
  data_t resp_data_o;
  cord_t resp_cord_o;
  logic  resp_ready_i;
  logic  finish_o;

  int    cyc = 0;
  int    n_checks = 0;
  int    n_errors = 0;
  int    test_errs = 0;
  data_t dram_ref [64];
  data_t scratch_ref;
  cord_t cord_ref;

  gw_mem_top gw_mem_top_inst (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp)
    else
    begin
      $display("** Error %s: got %h, expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("%-20s done, %0d errors", name, n_errors - test_errs);
    test_errs = n_errors;
  endtask

  // Payload goes in MSB first
  // New payload is live the cycle after the eighth bit
  task automatic load_tag(input tag_payload_t payload);
    for (int i = $bits(payload) - 1; i >= 0; i--)
    begin
      @(posedge clk_i);
      #1;
      tag_en_i   = 1'b1;
      tag_data_i = payload[i];
    end
    @(posedge clk_i);
    #1;
    tag_en_i = 1'b0;
  endtask

  task automatic send_cmd(input logic wr, input addr_t addr, input data_t data, output int acc);
    int waited;
    @(posedge clk_i);
    #1;
    cmd_v_i     = 1'b1;
    cmd_write_i = wr;
    cmd_addr_i  = addr;
    cmd_data_i  = data;
    acc         = -1;
    waited      = 0;
    while (acc < 0 && waited < max_wait_lp)
    begin
      @(negedge clk_i);
      if (cmd_yumi_o)
        acc = cyc;
      waited++;
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
    if (acc < 0)
    begin
      $display("Timeout: command to address %h was never accepted", addr);
      n_errors++;
    end
  endtask

  task automatic expect_resp(input data_t exp_data, input int lat, input int acc);
    int   waited;
    logic seen;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < max_wait_lp)
    begin
      @(negedge clk_i);
      seen = resp_v_o;
      waited++;
    end
    if (!seen)
    begin
      $display("Timeout: no response arrived for the accepted command");
      n_errors++;
    end
    else
    begin
      check_value("resp_data_o", resp_data_o, exp_data);
      check_value("resp_cord_o", resp_cord_o, cord_ref);
      if (acc >= 0)
        check_value("resp latency", cyc - acc, lat);
    end
  endtask

  // Command held valid while the soft reset is active
  task automatic hold_blocked(input int cycles);
    @(posedge clk_i);
    #1;
    cmd_v_i     = 1'b1;
    cmd_write_i = 1'b0;
    cmd_addr_i  = 16'h0001;
    repeat (cycles)
    begin
      @(negedge clk_i);
      check_value("cmd_yumi_o", cmd_yumi_o, 0);
      check_value("resp_v_o", resp_v_o, 0);
    end
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic soft_reset_gate();
    hold_blocked(20);
    report_test("soft reset gate");
  endtask

  task automatic tag_payload_load();
    int acc;
    cord_ref = 7'h2a;
    load_tag({1'b0, cord_ref});
    send_cmd(1'b0, 16'h0001, '0, acc);
    expect_resp('0, host_lat_lp, acc);
    report_test("tag load");
  endtask

  task automatic host_registers();
    int acc;
    scratch_ref = $urandom;
    send_cmd(1'b1, 16'h0001, scratch_ref, acc);
    expect_resp('0, host_lat_lp, acc);
    send_cmd(1'b0, 16'h0001, '0, acc);
    expect_resp(scratch_ref, host_lat_lp, acc);
    check_value("finish_o", finish_o, 0);
    send_cmd(1'b1, 16'h0000, $urandom, acc);
    expect_resp('0, host_lat_lp, acc);
    check_value("finish_o", finish_o, 1);
    send_cmd(1'b0, 16'h0000, '0, acc);
    expect_resp(32'h1, host_lat_lp, acc);
    report_test("host registers");
  endtask

  task automatic dram_path();
    addr_t addrs [5] = '{16'h8003, 16'h8010, 16'h803f, 16'h8003, 16'h8021};
    int    acc;
    data_t word;
    foreach (addrs[i])
    begin
      word = $urandom;
      dram_ref[addrs[i][5:0]] = word;
      send_cmd(1'b1, addrs[i], word, acc);
      expect_resp('0, dram_lat_lp, acc);
    end
    foreach (addrs[i])
    begin
      send_cmd(1'b0, addrs[i], '0, acc);
      expect_resp(dram_ref[addrs[i][5:0]], dram_lat_lp, acc);
    end
    report_test("dram path");
  endtask

  task automatic back_pressure();
    int acc;
    @(posedge clk_i);
    #1;
    resp_ready_i = 1'b0;
    send_cmd(1'b0, 16'h8010, '0, acc);
    expect_resp(dram_ref[6'h10], dram_lat_lp, acc);
    // Second command already waiting behind the stalled response
    @(posedge clk_i);
    #1;
    cmd_v_i     = 1'b1;
    cmd_write_i = 1'b0;
    cmd_addr_i  = 16'h0001;
    repeat (10)
    begin
      @(negedge clk_i);
      check_value("resp_v_o", resp_v_o, 1);
      check_value("resp_data_o", resp_data_o, dram_ref[6'h10]);
      check_value("cmd_yumi_o", cmd_yumi_o, 0);
    end
    @(posedge clk_i);
    #1;
    resp_ready_i = 1'b1;
    send_cmd(1'b0, 16'h0001, '0, acc);
    expect_resp(scratch_ref, host_lat_lp, acc);
    report_test("back pressure");
  endtask

  task automatic reconfiguration();
    int acc;
    cord_ref = 7'h15;
    load_tag({1'b1, cord_ref});
    hold_blocked(20);
    cord_ref = 7'h55;
    load_tag({1'b0, cord_ref});
    send_cmd(1'b0, 16'h803f, '0, acc);
    expect_resp(dram_ref[6'h3f], dram_lat_lp, acc);
    report_test("reconfiguration");
  endtask

  initial
  begin
    void'($urandom(32'h144c_e3a3));
    rst_n_i      = 1'b0;
    tag_en_i     = 1'b0;
    tag_data_i   = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_addr_i   = '0;
    cmd_write_i  = 1'b0;
    cmd_data_i   = '0;
    resp_ready_i = 1'b1;
    cord_ref     = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    soft_reset_gate();
    tag_payload_load();
    host_registers();
    dram_path();
    back_pressure();
    reconfiguration();

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule
